//--- verilog/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and instruction width
`define XLEN 32
// data memory depth in words
`define MEM_WORDS 32

// sequencer state codes
`define ST_FETCH     4'b0000
`define ST_DECODE    4'b0001
`define ST_EXEC      4'b0010
`define ST_MEM_LOAD  4'b0011
`define ST_WRITEBACK 4'b0100
`define ST_MEM_STORE 4'b0110
`define ST_ALU_PASS  4'b0111

// RV32I major opcodes, supported subset only
`define OP_RTYPE  7'b0110011
`define OP_ADDI   7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011

// alu operation select
`define ALU_ADD 2'b00
`define ALU_SUB 2'b01
`define ALU_AND 2'b10
`define ALU_OR  2'b11

`endif

//--- verilog/cpuPkg.sv
package cpuPkg;

    // one instruction word, four decode views over the same 32 bits
    typedef union packed {
        // register-register ops
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        // addi and lw
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        // sw, immediate split around rs2/rs1
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        // beq, scrambled branch offset
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
    } instrWord;

endpackage

//--- verilog/controlFsm.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module controlFsm (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::instrWord instr,
    input  logic             aluZero,
    output logic [3:0]       state,
    output logic             memWrite,
    output logic             memRead,
    output logic             regWriteEn,
    output logic             memToReg,
    output logic             aluSrcImm,
    output logic             branchTaken,
    output logic             retire,
    output logic [1:0]       aluOp
);

    logic [3:0] nextState;
    logic [6:0] opcode;
    logic       isBranch;

    // all decode works off the held instruction register
    assign opcode   = instr.rType.opcode;
    assign isBranch = (opcode == `OP_BRANCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= `ST_FETCH;
        end else begin
            state <= nextState;
        end
    end

    // fetch -> decode -> exec, then split per instruction class
    always_comb begin
        case (state)
            `ST_FETCH: begin
                nextState = `ST_DECODE;
            end
            `ST_DECODE: begin
                nextState = `ST_EXEC;
            end
            `ST_EXEC: begin
                case (opcode)
                    `OP_LOAD:   nextState = `ST_MEM_LOAD;
                    `OP_STORE:  nextState = `ST_MEM_STORE;
                    // beq finishes here
                    `OP_BRANCH: nextState = `ST_FETCH;
                    // R-type and addi go through the alu pass state
                    default:    nextState = `ST_ALU_PASS;
                endcase
            end
            `ST_MEM_LOAD, `ST_ALU_PASS: begin
                nextState = `ST_WRITEBACK;
            end
            // writeback, store and any stray code return to fetch
            default: begin
                nextState = `ST_FETCH;
            end
        endcase
    end

    // strobes only in their own states
    assign memWrite   = (state == `ST_MEM_STORE);
    assign memRead    = (state == `ST_MEM_LOAD);
    assign regWriteEn = (state == `ST_WRITEBACK);

    // load data vs alu pass value at writeback
    assign memToReg = (opcode == `OP_LOAD);

    // immediate operand for addi, lw, sw
    assign aluSrcImm = (opcode == `OP_ADDI) || (opcode == `OP_LOAD) || (opcode == `OP_STORE);

    // beq taken when rs1 - rs2 is zero
    assign branchTaken = (state == `ST_EXEC) && isBranch && aluZero;

    // last state of each class
    assign retire = (state == `ST_WRITEBACK) || (state == `ST_MEM_STORE) ||
                    ((state == `ST_EXEC) && isBranch);

    // funct3/funct7 to alu op, address math defaults to add
    always_comb begin
        aluOp = `ALU_ADD;
        if (isBranch) begin
            aluOp = `ALU_SUB;
        end else if (opcode == `OP_RTYPE) begin
            case (instr.rType.funct3)
                // funct7 bit 5 picks sub over add
                3'b000:  aluOp = instr.rType.funct7[5] ? `ALU_SUB : `ALU_ADD;
                3'b110:  aluOp = `ALU_OR;
                3'b111:  aluOp = `ALU_AND;
                default: aluOp = `ALU_ADD;
            endcase
        end
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic             writeEn,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [32];

    // x0 never written, everything cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rdAddr != 5'd0)) begin
            regs[rdAddr] <= writeData;
        end
    end

    // async read ports
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
    input  cpuPkg::instrWord instr,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  logic             aluSrcImm,
    input  logic [1:0]       aluOp,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] srcB;

    // sign-extended I and S immediates
    assign immI = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
    assign immS = {{(`XLEN-12){instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};

    // only sw uses the split S layout
    assign imm  = (instr.sType.opcode == `OP_STORE) ? immS : immI;
    assign srcB = aluSrcImm ? imm : opB;

    always_comb begin
        case (aluOp)
            `ALU_SUB: result = opA - srcB;
            `ALU_AND: result = opA & srcB;
            `ALU_OR:  result = opA | srcB;
            default:  result = opA + srcB;
        endcase
    end

    // beq equality test
    assign zero = (result == '0);

endmodule

//--- verilog/dataMemory.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module dataMemory (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       state,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] storeData,
    input  logic             memWrite,
    input  logic             memRead,
    output logic [`XLEN-1:0] readData,
    output logic [`XLEN-1:0] aluPass
);

    logic [`XLEN-1:0] mem [`MEM_WORDS];
    logic [4:0]       wordIdx;
    logic             active;

    // byte address to word index
    assign wordIdx = aluResult[6:2];

    // memory only acts in these three states
    assign active = (state == `ST_MEM_LOAD) || (state == `ST_MEM_STORE) ||
                    (state == `ST_ALU_PASS);

    // array clears on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (active && memWrite) begin
            mem[wordIdx] <= storeData;
        end
    end

    // load data and the forwarded alu value for writeback
    always_ff @(posedge clk) begin
        if (active) begin
            if (memRead) begin
                readData <= mem[wordIdx];
            end
            // every active state forwards the address/result
            aluPass <= aluResult;
        end
    end

endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTop (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] pc,
    output logic             retire,
    output logic             regWriteEn,
    output logic [4:0]       regWriteAddr,
    output logic [`XLEN-1:0] regWriteData
);

    import cpuPkg::*;

    instrWord         ir;
    logic [3:0]       state;
    logic             memWrite;
    logic             memRead;
    logic             memToReg;
    logic             aluSrcImm;
    logic             branchTaken;
    logic             aluZero;
    logic [1:0]       aluOp;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluRes;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] readData;
    logic [`XLEN-1:0] aluPass;
    logic [`XLEN-1:0] immB;

    // B-immediate, bit 0 always zero
    assign immB = {{(`XLEN-12){ir.bType.imm12}}, ir.bType.imm11, ir.bType.imm10to5,
                   ir.bType.imm4to1, 1'b0};

    // pc already points past the branch, step back before adding the offset
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (state == `ST_FETCH) begin
            pc <= pc + 32'd4;
        end else if (branchTaken) begin
            pc <= pc - 32'd4 + immB;
        end
    end

    // instruction, operands and alu result, each latched in its own state
    always_ff @(posedge clk) begin
        if (state == `ST_FETCH) begin
            ir <= instr;
        end
        if (state == `ST_DECODE) begin
            opA <= rs1Data;
            opB <= rs2Data;
        end
        if (state == `ST_EXEC) begin
            aluOut <= aluRes;
        end
    end

    controlFsm uControl (
        .clk(clk), .rst(rst), .instr(ir), .aluZero(aluZero), .state(state),
        .memWrite(memWrite), .memRead(memRead), .regWriteEn(regWriteEn),
        .memToReg(memToReg), .aluSrcImm(aluSrcImm), .branchTaken(branchTaken),
        .retire(retire), .aluOp(aluOp)
    );

    regFile uRegs (
        .clk(clk), .rst(rst), .rs1Addr(ir.rType.rs1), .rs2Addr(ir.rType.rs2),
        .rdAddr(regWriteAddr), .writeEn(regWriteEn), .writeData(regWriteData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu uAlu (
        .instr(ir), .opA(opA), .opB(opB), .aluSrcImm(aluSrcImm), .aluOp(aluOp),
        .result(aluRes), .zero(aluZero)
    );

    // store data comes from the rs2 operand register
    dataMemory uMem (
        .clk(clk), .rst(rst), .state(state), .aluResult(aluOut), .storeData(opB),
        .memWrite(memWrite), .memRead(memRead), .readData(readData), .aluPass(aluPass)
    );

    // writeback trace, also feeds the register file
    assign regWriteAddr = ir.rType.rd;
    assign regWriteData = memToReg ? readData : aluPass;

endmodule

//--- verif/cpuChecker.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuChecker (
    input logic       clk,
    input logic       rst,
    input logic [3:0] state,
    input logic       regWriteEn,
    input logic       retire,
    input logic       memWrite,
    input logic       memRead
);

    // writeback strobe lasts a single cycle
    writebackOneCycle: assert property (
        @(posedge clk) disable iff (rst) regWriteEn |=> !regWriteEn
    ) else $error("regWriteEn high two cycles in a row");

    // a reset edge leaves both trace strobes low
    quietInReset: assert property (
        @(posedge clk) rst |=> (!retire && !regWriteEn)
    ) else $error("retire or regWriteEn high during reset");

    // only the seven sequencer codes
    stateLegal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {`ST_FETCH, `ST_DECODE, `ST_EXEC, `ST_MEM_LOAD,
                      `ST_WRITEBACK, `ST_MEM_STORE, `ST_ALU_PASS}
    ) else $error("sequencer in an undefined state %b", state);

    // load and store strobes are exclusive
    memStrobesExclusive: assert property (
        @(posedge clk) disable iff (rst) !(memWrite && memRead)
    ) else $error("memWrite and memRead high together");

endmodule

bind cpuTop cpuChecker uChecker (
    .clk(clk),
    .rst(rst),
    .state(state),
    .regWriteEn(regWriteEn),
    .retire(retire),
    .memWrite(memWrite),
    .memRead(memRead)
);

//--- verif/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb;

    localparam int PROG_LEN = 60;
    // worst case five cycles per instruction plus slack
    localparam int CYCLE_LIMIT = PROG_LEN * 5 + 50;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = {12'd0, 5'd0, 3'b000, 5'd0, `OP_ADDI};

    typedef enum int {kindAdd, kindSub, kindAnd, kindOr, kindAddi, kindLoad, kindStore,
                      kindBeq} instrKind;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retire;
    logic        regWriteEn;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteData;

    // generated program words plus decoded fields for the model
    logic [31:0] progWord [PROG_LEN];
    instrKind    progKind [PROG_LEN];
    int          progRd [PROG_LEN];
    int          progRs1 [PROG_LEN];
    int          progRs2 [PROG_LEN];
    int          progImm [PROG_LEN];

    // reference state
    logic [31:0] modelRegs [8];
    logic [31:0] modelMem [32];
    logic [31:0] modelPc;
    logic [31:0] lfsrState;

    int   cycleCount = 0;
    int   totalCycles = 0;
    int   lastRetireCycle = 0;
    int   retireCount = 0;
    int   executedCount = 0;
    logic pcCheckDue = 1'b0;
    logic runDone = 1'b0;

    cpuTop dut (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .retire(retire),
        .regWriteEn(regWriteEn),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois step with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic takeBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h",
                     $time, name, got, expected);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkQuiet();
        checkValue("pc", pc, 32'd0);
        checkValue("regWriteEn", regWriteEn, 1'b0);
        checkValue("retire", retire, 1'b0);
    endtask

    // cycles from fetch to retire for the instruction at a byte address
    function automatic int cyclesFor(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx >= PROG_LEN) begin
            return 5;
        end
        case (progKind[idx])
            kindStore: return 4;
            kindBeq: return 3;
            default: return 5;
        endcase
    endfunction

    // registers x0..x7 with lw/sw on base x0 and beq jumping forward 8 or 12
    task automatic buildProgram();
        int sel;
        int v;
        int lastStoreImm;
        logic haveStore;
        logic [12:0] off;
        lastStoreImm = 0;
        haveStore = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            takeBits(3, sel);
            progKind[i] = instrKind'(sel);
            takeBits(3, progRd[i]);
            takeBits(3, progRs1[i]);
            takeBits(3, progRs2[i]);
            progImm[i] = 0;
            case (progKind[i])
                kindAdd: progWord[i] = {7'b0000000, 5'(progRs2[i]), 5'(progRs1[i]), 3'b000,
                                        5'(progRd[i]), `OP_RTYPE};
                kindSub: progWord[i] = {7'b0100000, 5'(progRs2[i]), 5'(progRs1[i]), 3'b000,
                                        5'(progRd[i]), `OP_RTYPE};
                kindAnd: progWord[i] = {7'b0000000, 5'(progRs2[i]), 5'(progRs1[i]), 3'b111,
                                        5'(progRd[i]), `OP_RTYPE};
                kindOr: progWord[i] = {7'b0000000, 5'(progRs2[i]), 5'(progRs1[i]), 3'b110,
                                       5'(progRd[i]), `OP_RTYPE};
                kindAddi: begin
                    // small signed immediate from -16 to 15
                    takeBits(5, v);
                    progImm[i] = v - 16;
                    progWord[i] = {12'(progImm[i]), 5'(progRs1[i]), 3'b000, 5'(progRd[i]),
                                   `OP_ADDI};
                end
                kindLoad: begin
                    takeBits(5, v);
                    progImm[i] = v * 4;
                    // about half the loads reread the last stored word
                    takeBits(1, v);
                    if (haveStore && (v != 0)) begin
                        progImm[i] = lastStoreImm;
                    end
                    progRs1[i] = 0;
                    progWord[i] = {12'(progImm[i]), 5'd0, 3'b010, 5'(progRd[i]), `OP_LOAD};
                end
                kindStore: begin
                    takeBits(5, v);
                    progImm[i] = v * 4;
                    progRs1[i] = 0;
                    lastStoreImm = progImm[i];
                    haveStore = 1'b1;
                    progWord[i] = {7'(progImm[i] >> 5), 5'(progRs2[i]), 5'd0, 3'b010,
                                   5'(progImm[i]), `OP_STORE};
                end
                default: begin
                    takeBits(1, v);
                    progImm[i] = (v != 0) ? 12 : 8;
                    // half the branches compare a register with itself
                    takeBits(1, v);
                    if (v != 0) begin
                        progRs2[i] = progRs1[i];
                    end
                    off = 13'(progImm[i]);
                    progWord[i] = {off[12], off[10:5], 5'(progRs2[i]), 5'(progRs1[i]), 3'b000,
                                   off[4:1], off[11], `OP_BRANCH};
                end
            endcase
        end
    endtask

    // execute the instruction at modelPc and check the trace of its last cycle
    task automatic stepModel();
        int idx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic writes;
        idx = int'(modelPc >> 2);
        a = modelRegs[progRs1[idx]];
        b = modelRegs[progRs2[idx]];
        writes = 1'b1;
        value = '0;
        modelPc = modelPc + 32'd4;
        case (progKind[idx])
            kindAdd: value = a + b;
            kindSub: value = a - b;
            kindAnd: value = a & b;
            kindOr: value = a | b;
            kindAddi: value = a + progImm[idx];
            kindLoad: value = modelMem[progImm[idx] / 4];
            kindStore: begin
                writes = 1'b0;
                modelMem[progImm[idx] / 4] = b;
            end
            default: begin
                writes = 1'b0;
                if (a == b) begin
                    modelPc = modelPc - 32'd4 + progImm[idx];
                end
            end
        endcase
        executedCount++;
        lastRetireCycle = cycleCount;
        checkValue("retire", retire, 1'b1);
        checkValue("regWriteEn", regWriteEn, writes);
        if (writes) begin
            checkValue("regWriteAddr", regWriteAddr, progRd[idx]);
            checkValue("regWriteData", regWriteData, value);
            // x0 stays zero in the model
            if (progRd[idx] != 0) begin
                modelRegs[progRd[idx]] = value;
            end
        end
    endtask

    // instruction word follows the pc of the last edge
    always @(posedge clk) begin
        #1;
        if (pc < PROG_LEN * 4) begin
            instr = progWord[pc >> 2];
        end else begin
            instr = NOP_WORD;
        end
    end

    // sampled mid-cycle away from the drive edge
    always @(negedge clk) begin
        if (rst) begin
            checkQuiet();
        end else if (!runDone) begin
            cycleCount++;
            if (cycleCount == 1) begin
                checkQuiet();
            end
            // cycle after a retire is the next fetch
            if (pcCheckDue) begin
                checkValue("pc", pc, modelPc);
                pcCheckDue = 1'b0;
                if (modelPc >= PROG_LEN * 4) begin
                    runDone = 1'b1;
                end
            end
            if (retire) begin
                retireCount++;
            end
            // the model decides which cycle ends the current instruction
            if ((cycleCount - lastRetireCycle) == cyclesFor(modelPc)) begin
                stepModel();
                pcCheckDue = 1'b1;
            end else begin
                checkValue("regWriteEn", regWriteEn, 1'b0);
            end
        end
    end

    always @(posedge clk) begin
        totalCycles++;
        if (totalCycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles before the program finished",
                     totalCycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst = 1'b1;
        instr = NOP_WORD;
        lfsrState = 32'h166814ce;
        modelPc = '0;
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end
        // data memory clears on reset
        for (int i = 0; i < 32; i++) begin
            modelMem[i] = '0;
        end
        buildProgram();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (runDone);
        checkValue("retired count", retireCount, executedCount);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/controlFsm.sv
verilog/regFile.sv
verilog/alu.sv
verilog/dataMemory.sv
verilog/cpuTop.sv
verif/cpuChecker.sv
verif/cpuTb.sv
